// File: logic/mem_format.sv
module mem_format
   import mem_stage_pkg::*;
(
   input  mem_op_t  op,
   input  qword_t   mem_data,
   output mem_res_t res
);

   word_t  mem_sext8;
   word_t  mem_sext16;
   word_t  mem_lo;
   word_t  mem_lo16_zext;
   qword_t load_value;
   eip_t   eip_sel;
   cseg_t  cs_sel;
   word_t  ret_imm;
   logic   is_ret;

   // Load extension candidates
   assign mem_sext8     = {{24{mem_data[7]}}, mem_data[7:0]};
   assign mem_sext16    = {{16{mem_data[15]}}, mem_data[15:0]};
   assign mem_lo        = mem_data[31:0];
   // 16-bit pointer form used by short returns and jumps
   assign mem_lo16_zext = {16'b0, mem_data[15:0]};

   // Loaded value by operand size
   // 32-bit results leave the upper half clear
   always_comb begin
      case (op.size)
         2'd0:    load_value = {32'b0, mem_sext8};
         2'd1:    load_value = {32'b0, mem_sext16};
         2'd2:    load_value = {32'b0, mem_lo};
         default: load_value = mem_data;
      endcase
   end

   // Next EIP and CS
   always_comb begin
      // Sequential flow keeps the decoded next pointer
      eip_sel = op.neip;
      cs_sel  = op.ncs;
      case (op.kind)
         OP_JMP_REG: begin
            // Target comes straight from the register operand
            eip_sel = op.a;
            cs_sel  = op.ncs;
         end
         OP_JMP_MEM,
         OP_NEAR_RET: begin
            // Near transfer, segment unchanged
            if (op.size == 2'd2) begin
               eip_sel = mem_lo;
            end else begin
               eip_sel = mem_lo16_zext;
            end
            cs_sel = op.ncs;
         end
         OP_FAR_RET: begin
            if (op.size == 2'd3) begin
               // 32-bit offset followed by selector
               eip_sel = mem_lo;
               cs_sel  = mem_data[47:32];
            end else begin
               // 16-bit offset followed by selector
               eip_sel = mem_lo16_zext;
               cs_sel  = mem_data[31:16];
            end
         end
         OP_IDT_LOAD: begin
            // Gate descriptor splits the offset around the selector
            eip_sel = {mem_data[63:48], mem_data[15:0]};
            cs_sel  = mem_data[31:16];
         end
         default: begin
            eip_sel = op.neip;
            cs_sel  = op.ncs;
         end
      endcase
   end

   // RET imm16 pops extra bytes, immediate is unsigned
   assign is_ret  = (op.kind == OP_NEAR_RET) || (op.kind == OP_FAR_RET);
   assign ret_imm = is_ret ? {16'b0, op.b[15:0]} : 32'b0;

   always_comb begin
      res.eip     = eip_sel;
      res.cs      = cs_sel;
      res.sp_next = op.sp + ret_imm;
      res.dest    = op.dest;
      // Only loads return memory data, everything else forwards A
      if (op.kind == OP_LOAD) begin
         res.value = load_value;
      end else begin
         res.value = {32'b0, op.a};
      end
   end

endmodule

// File: logic/mem_issue.sv
module mem_issue
   import mem_stage_pkg::*;
(
   input  logic    clk,
   input  logic    reset,

   // Op input handshake
   input  logic    in_valid,
   output logic    in_ready,
   input  mem_op_t in_op,

   // Wishbone classic read port
   output wb_req_t wb_req,
   input  qword_t  wb_dat,
   input  logic    wb_ack,

   // Held op and memory word toward format and retire
   output logic    hold_valid,
   output mem_op_t hold_op,
   output qword_t  hold_data,
   input  logic    take
);

   issue_state_t state_q;
   issue_state_t state_d;
   mem_op_t      op_q;
   qword_t       data_q;
   logic         accept;
   logic         needs_read;

   // Kinds that fetch a memory word before formatting
   always_comb begin
      case (in_op.kind)
         OP_LOAD,
         OP_JMP_MEM,
         OP_NEAR_RET,
         OP_FAR_RET,
         OP_IDT_LOAD: needs_read = 1'b1;
         default:     needs_read = 1'b0;
      endcase
   end

   assign in_ready = (state_q == ST_IDLE);
   assign accept   = in_valid && in_ready;

   // Next state
   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (accept) begin
               // Register-only ops skip the bus entirely
               state_d = needs_read ? ST_BUS : ST_HOLD;
            end
         end
         ST_BUS: begin
            // Single-beat read ends on ack
            if (wb_ack) begin
               state_d = ST_HOLD;
            end
         end
         ST_HOLD: begin
            if (take) begin
               state_d = ST_IDLE;
            end
         end
         default: state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Op and data payload
   always_ff @(posedge clk) begin
      if (accept) begin
         op_q <= in_op;
      end
      // Data is valid only in the ack cycle
      if ((state_q == ST_BUS) && wb_ack) begin
         data_q <= wb_dat;
      end
   end

   // cyc and stb follow the state, so they rise with adr and drop right after ack
   assign wb_req.cyc = (state_q == ST_BUS);
   assign wb_req.stb = (state_q == ST_BUS);
   // Address comes from the latched op and is steady for the whole cycle
   assign wb_req.adr = op_q.addr;

   assign hold_valid = (state_q == ST_HOLD);
   assign hold_op    = op_q;
   assign hold_data  = data_q;

endmodule

// File: logic/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Bus geometry for the read-only Wishbone port

// Byte address of the read
`define MEM_ADDR_W 32

// One full memory word per read
`define MEM_DATA_W 64

// Result buffer between format logic and the next stage
// Two entries keep the output streaming while one result waits on out_ready
`define RETIRE_DEPTH 2

`endif

// File: logic/mem_retire.sv
`include "mem_params.svh"

module mem_retire
   import mem_stage_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     in_valid,
   input  mem_res_t in_res,
   output logic     take,
   output logic     out_valid,
   input  logic     out_ready,
   output mem_res_t out_res
);

   localparam int PTR_W = (`RETIRE_DEPTH > 1) ? $clog2(`RETIRE_DEPTH) : 1;
   localparam int CNT_W = $clog2(`RETIRE_DEPTH + 1);

   mem_res_t         entries [`RETIRE_DEPTH];
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W-1:0] wr_ptr;
   logic [CNT_W-1:0] count;
   logic             push;
   logic             pop;

   // Room check ignores a same-cycle pop
   assign take      = (count < CNT_W'(`RETIRE_DEPTH));
   assign out_valid = (count != '0);
   assign push      = in_valid && take;
   assign pop       = out_valid && out_ready;

   // Oldest result
   assign out_res = entries[rd_ptr];

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(`RETIRE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(`RETIRE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // Simultaneous push and pop leaves the count alone
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

   // Result storage
   always_ff @(posedge clk) begin
      if (push) begin
         entries[wr_ptr] <= in_res;
      end
   end

endmodule

// File: logic/mem_stage_pkg.sv
`include "mem_params.svh"

package mem_stage_pkg;

   // Plain vectors for widths with a meaning
   typedef logic [`MEM_ADDR_W-1:0] addr_t;
   typedef logic [31:0]            eip_t;
   typedef logic [15:0]            cseg_t;
   typedef logic [31:0]            word_t;
   typedef logic [`MEM_DATA_W-1:0] qword_t;

   // Operand size: 0 byte, 1 word, 2 dword, 3 qword
   typedef logic [1:0]             mem_size_t;
   typedef logic [2:0]             reg_id_t;

   // Kind of micro-op seen by this stage
   // Every kind except OP_PASS and OP_JMP_REG reads memory
   typedef enum logic [2:0] {
      OP_PASS,
      OP_LOAD,
      OP_JMP_REG,
      OP_JMP_MEM,
      OP_NEAR_RET,
      OP_FAR_RET,
      OP_IDT_LOAD
   } op_kind_t;

   // Issue side FSM
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_BUS,
      ST_HOLD
   } issue_state_t;

   // Decoded op entering the stage
   typedef struct packed {
      op_kind_t  kind;
      mem_size_t size;
      addr_t     addr;
      word_t     a;
      // Low half carries the return immediate
      word_t     b;
      word_t     sp;
      eip_t      neip;
      cseg_t     ncs;
      reg_id_t   dest;
   } mem_op_t;

   // Stage results in retire order
   typedef struct packed {
      qword_t  value;
      eip_t    eip;
      cseg_t   cs;
      word_t   sp_next;
      reg_id_t dest;
   } mem_res_t;

   // Wishbone classic read request
   typedef struct packed {
      logic  cyc;
      logic  stb;
      addr_t adr;
   } wb_req_t;

endpackage

// File: logic/mem_stage_top.sv
module mem_stage_top
   import mem_stage_pkg::*;
(
   input  logic     clk,
   input  logic     reset,

   input  logic     in_valid,
   output logic     in_ready,
   input  mem_op_t  in_op,

   output wb_req_t  wb_req,
   input  qword_t   wb_dat,
   input  logic     wb_ack,

   output logic     out_valid,
   input  logic     out_ready,
   output mem_res_t out_res
);

   logic     hold_valid;
   mem_op_t  hold_op;
   qword_t   hold_data;
   logic     take;
   mem_res_t fmt_res;

   // Accepts ops and runs the memory read
   mem_issue mem_issue_inst (
      .clk        (clk),
      .reset      (reset),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .in_op      (in_op),
      .wb_req     (wb_req),
      .wb_dat     (wb_dat),
      .wb_ack     (wb_ack),
      .hold_valid (hold_valid),
      .hold_op    (hold_op),
      .hold_data  (hold_data),
      .take       (take)
   );

   // Result forming sits between the hold registers and the buffer
   mem_format mem_format_inst (
      .op       (hold_op),
      .mem_data (hold_data),
      .res      (fmt_res)
   );

   // In-order output buffer
   mem_retire mem_retire_inst (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (hold_valid),
      .in_res    (fmt_res),
      .take      (take),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_res   (out_res)
   );

endmodule

// File: testbench/mem_stage_assert.sv
module mem_stage_assert
   import mem_stage_pkg::*;
(
   input logic     clk,
   input logic     reset,
   input wb_req_t  wb_req,
   input logic     wb_ack,
   input logic     out_valid,
   input logic     out_ready,
   input mem_res_t out_res
);

   // Address held while the strobe waits for ack
   property adr_stable_p;
      @(posedge clk) disable iff (reset)
         (wb_req.stb && !wb_ack) |=> $stable(wb_req.adr);
   endproperty

   // Stalled output keeps valid and its payload
   property out_hold_p;
      @(posedge clk) disable iff (reset)
         (out_valid && !out_ready) |=> (out_valid && $stable(out_res));
   endproperty

   // Bus idle right after reset
   property cyc_reset_p;
      @(posedge clk) reset |=> (!wb_req.cyc && !wb_req.stb);
   endproperty

   assert property (adr_stable_p) else $error("wishbone adr changed before ack");
   assert property (out_hold_p) else $error("out_valid or out_res changed while stalled");
   assert property (cyc_reset_p) else $error("wishbone cyc high after reset");

endmodule

bind mem_stage_top mem_stage_assert mem_stage_assert_inst (
   .clk       (clk),
   .reset     (reset),
   .wb_req    (wb_req),
   .wb_ack    (wb_ack),
   .out_valid (out_valid),
   .out_ready (out_ready),
   .out_res   (out_res)
);

// File: testbench/mem_stage_tb.sv
module mem_stage_tb
   import mem_stage_pkg::*;
;

   // Op counts per test
   localparam int N_LOAD = 24;
   localparam int N_NEAR = 24;
   localparam int N_FAR = 16;
   localparam int N_REG = 16;
   localparam int N_BP = 40;
   localparam int N_B2B = 24;
   localparam int RESET_CYCLES = 4;
   localparam int N_OPS = N_LOAD + N_NEAR + N_FAR + N_REG + N_BP + N_B2B;
   localparam int WATCHDOG_CYCLES = N_OPS * 40 + RESET_CYCLES;

   // Op mixes
   localparam int MIX_LOAD = 0;
   localparam int MIX_NEAR = 1;
   localparam int MIX_FAR = 2;
   localparam int MIX_REG = 3;
   localparam int MIX_ANY = 4;

   logic     clk;
   logic     reset;
   logic     in_valid;
   logic     in_ready;
   mem_op_t  in_op;
   wb_req_t  wb_req;
   qword_t   wb_dat;
   logic     wb_ack;
   logic     out_valid;
   logic     out_ready;
   mem_res_t out_res;

   string       test_name;
   int          cycle_no;
   int          max_ack_wait;
   int          ack_wait;
   logic        bus_open;
   logic        random_ready;
   int          ready_left;
   logic        check_timing;
   op_kind_t    issue_kind;
   mem_res_t    exp_res;
   int          acc_cycle;
   int          exp_lat;
   mem_res_t    exp_q[$];
   int          acc_q[$];
   int          lat_q[$];

   mem_stage_top mem_stage_top_inst (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_op     (in_op),
      .wb_req    (wb_req),
      .wb_dat    (wb_dat),
      .wb_ack    (wb_ack),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_res   (out_res)
   );

   always #5 clk = ~clk;

   task automatic stop_run();
      $display("Something failed");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_value(input qword_t exp, input qword_t act);
      if (act !== exp) begin
         $display("ERROR %s value expected %h actual %h", test_name, exp, act);
         stop_run();
      end
   endtask

   task automatic check_eip(input eip_t exp, input eip_t act);
      if (act !== exp) begin
         $display("ERROR %s eip expected %h actual %h", test_name, exp, act);
         stop_run();
      end
   endtask

   task automatic check_cs(input cseg_t exp, input cseg_t act);
      if (act !== exp) begin
         $display("ERROR %s cs expected %h actual %h", test_name, exp, act);
         stop_run();
      end
   endtask

   task automatic check_sp(input word_t exp, input word_t act);
      if (act !== exp) begin
         $display("ERROR %s sp expected %h actual %h", test_name, exp, act);
         stop_run();
      end
   endtask

   task automatic check_dest(input reg_id_t exp, input reg_id_t act);
      if (act !== exp) begin
         $display("ERROR %s dest expected %0d actual %0d", test_name, exp, act);
         stop_run();
      end
   endtask

   // Edges from acceptance to output transfer
   task automatic check_latency(input int exp, input int act);
      if (act != exp) begin
         $display("ERROR %s latency expected %0d actual %0d", test_name, exp, act);
         stop_run();
      end
   endtask

   // Only pass and register jumps stay off the bus
   function automatic logic needs_memory(input op_kind_t kind);
      return (kind != OP_PASS) && (kind != OP_JMP_REG);
   endfunction

   // Reference model of the result rules
   function automatic mem_res_t expect_res(input mem_op_t op);
      qword_t   m;
      mem_res_t r;
      m = {op.addr, ~op.addr};
      r.value = {32'b0, op.a};
      r.eip = op.neip;
      r.cs = op.ncs;
      r.sp_next = op.sp;
      r.dest = op.dest;
      case (op.kind)
         OP_LOAD: begin
            if (op.size == 2'd0) r.value = {32'b0, {24{m[7]}}, m[7:0]};
            else if (op.size == 2'd1) r.value = {32'b0, {16{m[15]}}, m[15:0]};
            else if (op.size == 2'd2) r.value = {32'b0, m[31:0]};
            else r.value = m;
         end
         OP_JMP_REG: r.eip = op.a;
         OP_JMP_MEM, OP_NEAR_RET: begin
            r.eip = (op.size == 2'd2) ? m[31:0] : {16'b0, m[15:0]};
         end
         OP_FAR_RET: begin
            r.eip = (op.size == 2'd3) ? m[31:0] : {16'b0, m[15:0]};
            r.cs = (op.size == 2'd3) ? m[47:32] : m[31:16];
         end
         OP_IDT_LOAD: begin
            r.eip = {m[63:48], m[15:0]};
            r.cs = m[31:16];
         end
         default: ;
      endcase
      // Return immediate is unsigned
      if ((op.kind == OP_NEAR_RET) || (op.kind == OP_FAR_RET)) begin
         r.sp_next = op.sp + {16'b0, op.b[15:0]};
      end
      return r;
   endfunction

   function automatic mem_op_t pick_op(input int mix);
      mem_op_t op;
      int      sel;
      sel = int'($urandom_range(2, 0));
      op.size = mem_size_t'($urandom_range(3, 0));
      case (mix)
         MIX_LOAD: op.kind = OP_LOAD;
         MIX_NEAR: begin
            op.kind = (sel == 0) ? OP_JMP_REG : ((sel == 1) ? OP_JMP_MEM : OP_NEAR_RET);
            op.size = mem_size_t'($urandom_range(2, 1));
         end
         MIX_FAR: begin
            // Two thirds far returns at size 2 or 3 and the rest IDT loads
            op.kind = (sel == 2) ? OP_IDT_LOAD : OP_FAR_RET;
            if (sel != 2) op.size = mem_size_t'(2 + sel);
         end
         MIX_REG: op.kind = (sel == 0) ? OP_JMP_REG : OP_PASS;
         default: op.kind = op_kind_t'($urandom_range(6, 0));
      endcase
      op.addr = addr_t'($urandom());
      op.a = word_t'($urandom());
      op.b = word_t'($urandom());
      op.sp = word_t'($urandom());
      op.neip = eip_t'($urandom());
      op.ncs = cseg_t'($urandom());
      op.dest = reg_id_t'($urandom());
      return op;
   endfunction

   // Starts and ends just after a falling edge
   task automatic send_op(input mem_op_t op);
      in_op = op;
      in_valid = 1'b1;
      @(posedge clk);
      while (!in_ready) @(posedge clk);
      @(negedge clk);
      in_valid = 1'b0;
   endtask

   task automatic run_ops(input string name, input int mix, input int count);
      test_name = name;
      repeat (count) send_op(pick_op(mix));
      // Drain before the next test
      while (exp_q.size() != 0) @(negedge clk);
   endtask

   // Wishbone read memory with 0 to max_ack_wait wait states
   always @(negedge clk) begin
      wb_ack = 1'b0;
      if (!reset && wb_req.cyc && wb_req.stb) begin
         if (!needs_memory(issue_kind)) begin
            $display("ERROR %s: bus cycle started for a register-only op", test_name);
            stop_run();
         end
         if (!bus_open) begin
            bus_open = 1'b1;
            ack_wait = int'($urandom_range(max_ack_wait, 0));
         end
         if (ack_wait == 0) begin
            wb_ack = 1'b1;
            // Address above, inverted address below
            wb_dat = {wb_req.adr, ~wb_req.adr};
            bus_open = 1'b0;
         end else begin
            ack_wait = ack_wait - 1;
         end
      end
   end

   // Random out_ready runs with long low stretches
   always @(negedge clk) begin
      if (!random_ready) begin
         out_ready = 1'b1;
      end else begin
         if (ready_left == 0) begin
            out_ready = ($urandom_range(1, 0) == 1);
            ready_left = out_ready ? int'($urandom_range(4, 1)) : int'($urandom_range(12, 1));
         end
         ready_left = ready_left - 1;
      end
   end

   // Transfer monitor with in-order compare
   always @(posedge clk) begin
      if (!reset && in_valid && in_ready) begin
         exp_q.push_back(expect_res(in_op));
         acc_q.push_back(cycle_no);
         lat_q.push_back(needs_memory(in_op.kind) ? 3 : 2);
         issue_kind = in_op.kind;
      end
      if (!reset && out_valid && out_ready) begin
         if (exp_q.size() == 0) begin
            $display("ERROR %s: result delivered with no op outstanding", test_name);
            stop_run();
         end
         exp_res = exp_q.pop_front();
         acc_cycle = acc_q.pop_front();
         exp_lat = lat_q.pop_front();
         check_value(exp_res.value, out_res.value);
         check_eip(exp_res.eip, out_res.eip);
         check_cs(exp_res.cs, out_res.cs);
         check_sp(exp_res.sp_next, out_res.sp_next);
         check_dest(exp_res.dest, out_res.dest);
         if (check_timing) check_latency(exp_lat, cycle_no - acc_cycle);
      end
      cycle_no = cycle_no + 1;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("ERROR watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
      stop_run();
   end

   initial begin
      void'($urandom(32'hafc0));
      clk = 1'b0;
      reset = 1'b1;
      in_valid = 1'b0;
      in_op = '0;
      wb_dat = '0;
      wb_ack = 1'b0;
      out_ready = 1'b0;
      test_name = "reset";
      cycle_no = 0;
      max_ack_wait = 3;
      ack_wait = 0;
      bus_open = 1'b0;
      random_ready = 1'b0;
      ready_left = 0;
      check_timing = 1'b0;
      issue_kind = OP_LOAD;
      repeat (RESET_CYCLES) @(negedge clk);
      reset = 1'b0;
      run_ops("loads", MIX_LOAD, N_LOAD);
      run_ops("near_jumps", MIX_NEAR, N_NEAR);
      run_ops("far_returns", MIX_FAR, N_FAR);
      run_ops("register_ops", MIX_REG, N_REG);
      random_ready = 1'b1;
      run_ops("backpressure", MIX_ANY, N_BP);
      // Zero wait acks and ready held high give fixed latency
      random_ready = 1'b0;
      max_ack_wait = 0;
      check_timing = 1'b1;
      run_ops("back_to_back", MIX_ANY, N_B2B);
      // Every result out and no extra entry left in the buffer
      if ((exp_q.size() == 0) && !out_valid && in_ready) begin
         $display("Everything OK");
         $finish;
      end else begin
         $display("ERROR %s: DUT not idle after the last expected result", test_name);
         stop_run();
      end
   end

endmodule

// File: verilog.f
+incdir+logic
logic/mem_stage_pkg.sv
logic/mem_issue.sv
logic/mem_format.sv
logic/mem_retire.sv
logic/mem_stage_top.sv
testbench/mem_stage_assert.sv
testbench/mem_stage_tb.sv
